//--- hw/chirp_types_pkg.sv
package chirp_types_pkg;

  ////////////////////
  // word geometry
  ////////////////////

  // one sample word carries two half-word lanes
  localparam int SAMPLE_W = 32;
  localparam int LANE_W   = SAMPLE_W / 2;

  // signed half-word, used for re/imag and for each dual-real value
  typedef logic signed [LANE_W-1:0] lane_t;

  ////////////////////
  // sample word views
  ////////////////////

  // complex view, real part in the low half
  typedef struct packed {
    lane_t imag;
    lane_t re;
  } cplx_t;

  // dual-real view, two unrelated reals
  typedef struct packed {
    lane_t hi;
    lane_t lo;
  } dual_t;

  // same 32 bits, decoded by the frame mode
  // used for input samples, weights and results alike
  typedef union packed {
    cplx_t cplx;
    dual_t dual;
  } sample_u;

endpackage

//--- hw/chirp_cfg_pkg.sv
package chirp_cfg_pkg;

  ////////////////////
  // mode encoding
  ////////////////////

  // 0 selects complex multiply, 1 selects two real multiplies
  typedef enum logic {
    MODE_COMPLEX = 1'b0,
    MODE_REAL    = 1'b1
  } mode_e;

  ////////////////////
  // multiplier latency
  ////////////////////

  // cycles from multiplier input to registered result
  // complex: in reg, sum/diff, 3-stage mult, add, out reg
  localparam int LAT_COMPLEX = 6;
  // dual-real: in reg, 1-stage mult, out reg
  localparam int LAT_REAL    = 3;

endpackage

//--- hw/chirp_pipe_mult.sv
`timescale 1ns/1ps

module chirp_pipe_mult #(
  parameter int A_W   = 16,
  parameter int B_W   = 16,
  parameter int DELAY = 1
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic signed [A_W-1:0]       i_a,
  input  logic signed [B_W-1:0]       i_b,
  output logic signed [A_W+B_W-1:0]   o_p
);

  // full-width signed product, no truncation
  logic signed [A_W+B_W-1:0] prod;
  // product pipeline, stage 0 is the first register
  logic signed [A_W+B_W-1:0] pipe [DELAY];

  assign prod = i_a * i_b;

  // DELAY register stages behind the multiplier
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DELAY; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= prod;
      for (int i = 1; i < DELAY; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  // last stage is the product output
  assign o_p = pipe[DELAY-1];

endmodule

//--- hw/chirp_weight_ram.sv
`timescale 1ns/1ps

module chirp_weight_ram #(
  parameter int ADDR_W = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // write side, loaded between frames
  input  logic                     i_we,
  input  logic [ADDR_W-1:0]        i_waddr,
  input  chirp_types_pkg::sample_u i_wdata,
  // read side, driven by the sample count
  input  logic [ADDR_W-1:0]        i_raddr,
  output chirp_types_pkg::sample_u o_rdata
);

  localparam int DEPTH = 2 ** ADDR_W;

  ////////////////////
  // storage
  ////////////////////

  // one weight word per sample position
  chirp_types_pkg::sample_u mem [DEPTH];

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // registered read, weight shows up one cycle after the address
  // output reads zero out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rdata <= '0;
    end else begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule

//--- hw/chirp_weight_mult.sv
`timescale 1ns/1ps

module chirp_weight_mult (
  input  logic                     clk,
  input  logic                     rst_n,
  input  chirp_cfg_pkg::mode_e     i_mode,
  input  chirp_types_pkg::sample_u i_x,
  input  chirp_types_pkg::sample_u i_w,
  input  logic                     i_valid,
  output chirp_types_pkg::sample_u o_y,
  output logic                     o_valid
);

  localparam int LW    = chirp_types_pkg::LANE_W;
  localparam int PW    = 2 * LW;
  localparam int LAT_C = chirp_cfg_pkg::LAT_COMPLEX;
  localparam int LAT_R = chirp_cfg_pkg::LAT_REAL;

  // registered sample and weight
  chirp_types_pkg::sample_u x_q;
  chirp_types_pkg::sample_u w_q;

  // complex operands
  // a + jb is the sample, c + jd is the weight
  chirp_types_pkg::lane_t a;
  chirp_types_pkg::lane_t b;
  chirp_types_pkg::lane_t c;
  chirp_types_pkg::lane_t d;

  // dual-real products
  logic signed [PW-1:0]   p_hi;
  logic signed [PW-1:0]   p_lo;

  // complex intermediates
  logic signed [LW:0]     t_sum;
  logic signed [LW:0]     t_diff;
  logic signed [PW-1:0]   p_ad;
  logic signed [PW-1:0]   p_bc;
  logic signed [PW+1:0]   p_sd;
  logic signed [PW:0]     ad_m_bc;
  logic signed [PW:0]     im_q;
  logic signed [PW+1:0]   re_sum;

  // valid delay lines, one per mode
  logic [LAT_C-1:0]       vld_c_sr;
  logic [LAT_R-1:0]       vld_r_sr;
  logic                   load_y;

  ////////////////////
  // input register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_q <= '0;
      w_q <= '0;
    end else begin
      x_q <= i_x;
      w_q <= i_w;
    end
  end

  assign a = x_q.cplx.re;
  assign b = x_q.cplx.imag;
  assign c = w_q.cplx.re;
  assign d = w_q.cplx.imag;

  ////////////////////
  // dual-real path
  ////////////////////

  // each half times the matching weight half
  chirp_pipe_mult #(.A_W(LW), .B_W(LW), .DELAY(1)) u_mult_hi (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (x_q.dual.hi),
    .i_b   (w_q.dual.hi),
    .o_p   (p_hi)
  );

  chirp_pipe_mult #(.A_W(LW), .B_W(LW), .DELAY(1)) u_mult_lo (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (x_q.dual.lo),
    .i_b   (w_q.dual.lo),
    .o_p   (p_lo)
  );

  ////////////////////
  // complex path
  ////////////////////

  // 3-mult form
  // re = (ad - bc) + (a+b)(c-d) = ac - bd
  // im = ad + bc

  // a+b and c-d, one bit of growth each
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      t_sum  <= '0;
      t_diff <= '0;
    end else begin
      t_sum  <= a + b;
      t_diff <= c - d;
    end
  end

  chirp_pipe_mult #(.A_W(LW), .B_W(LW), .DELAY(3)) u_mult_ad (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (a),
    .i_b   (d),
    .o_p   (p_ad)
  );

  chirp_pipe_mult #(.A_W(LW), .B_W(LW), .DELAY(3)) u_mult_bc (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (b),
    .i_b   (c),
    .o_p   (p_bc)
  );

  // starts one cycle later than ad/bc, lands together with ad - bc
  chirp_pipe_mult #(.A_W(LW+1), .B_W(LW+1), .DELAY(3)) u_mult_sd (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (t_sum),
    .i_b   (t_diff),
    .o_p   (p_sd)
  );

  // ad - bc for the real part, ad + bc held one extra stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ad_m_bc <= '0;
      im_q    <= '0;
    end else begin
      ad_m_bc <= p_ad - p_bc;
      im_q    <= p_ad + p_bc;
    end
  end

  assign re_sum = ad_m_bc + p_sd;

  ////////////////////
  // valid tracking
  ////////////////////

  // only the active mode's line is fed, so the other one stays empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_c_sr <= '0;
      vld_r_sr <= '0;
    end else begin
      vld_c_sr <= {vld_c_sr[LAT_C-2:0], i_valid && (i_mode == chirp_cfg_pkg::MODE_COMPLEX)};
      vld_r_sr <= {vld_r_sr[LAT_R-2:0], i_valid && (i_mode == chirp_cfg_pkg::MODE_REAL)};
    end
  end

  assign o_valid = (i_mode == chirp_cfg_pkg::MODE_REAL) ? vld_r_sr[LAT_R-1] : vld_c_sr[LAT_C-1];

  // stage before the output, loads o_y
  assign load_y = (i_mode == chirp_cfg_pkg::MODE_REAL) ? vld_r_sr[LAT_R-2] : vld_c_sr[LAT_C-2];

  ////////////////////
  // output register
  ////////////////////

  // each lane packed as sign bit plus low 15 bits, no saturation
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_y <= '0;
    end else if (load_y) begin
      if (i_mode == chirp_cfg_pkg::MODE_REAL) begin
        o_y.dual.hi <= {p_hi[PW-1], p_hi[LW-2:0]};
        o_y.dual.lo <= {p_lo[PW-1], p_lo[LW-2:0]};
      end else begin
        o_y.cplx.imag <= {im_q[PW], im_q[LW-2:0]};
        o_y.cplx.re   <= {re_sum[PW+1], re_sum[LW-2:0]};
      end
    end
  end

  // result strobe is clean once out of reset
  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(o_valid));

  // mode held while anything is in flight
  assert property (@(posedge clk) disable iff (!rst_n)
    (|{vld_c_sr, vld_r_sr}) |=> $stable(i_mode));

endmodule

//--- hw/chirp_frame_ctrl.sv
`timescale 1ns/1ps

module chirp_frame_ctrl #(
  parameter int FRAME_LEN = 8,
  parameter int ADDR_W    = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // frame control
  input  logic                     i_frame_start,
  input  chirp_cfg_pkg::mode_e     i_mode,
  // incoming samples
  input  logic                     i_valid,
  input  chirp_types_pkg::sample_u i_x,
  // result strobe back from the multiplier
  input  logic                     i_y_valid,
  // to weight memory and multiplier
  output logic [ADDR_W-1:0]        o_raddr,
  output chirp_cfg_pkg::mode_e     o_mode,
  output chirp_types_pkg::sample_u o_x,
  output logic                     o_x_valid,
  // status
  output logic                     o_busy,
  output logic                     o_frame_done
);

  // counts run 0..FRAME_LEN
  localparam int CNT_W = $clog2(FRAME_LEN + 1);

  logic [CNT_W-1:0] in_cnt;
  logic [CNT_W-1:0] out_cnt;
  logic             accept;
  logic             last_out;

  // sample taken only inside a frame and only FRAME_LEN of them
  assign accept   = o_busy && i_valid && (in_cnt < CNT_W'(FRAME_LEN));
  assign last_out = i_y_valid && (out_cnt == CNT_W'(FRAME_LEN - 1));

  // done pulses with the last result
  assign o_frame_done = o_busy && last_out;

  // weight slot follows the sample count
  // memory registers it, so the weight lines up with o_x
  assign o_raddr = in_cnt[ADDR_W-1:0];

  ////////////////////
  // frame state
  ////////////////////

  // mode only latched on an accepted start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_busy <= 1'b0;
      o_mode <= chirp_cfg_pkg::MODE_COMPLEX;
    end else if (!o_busy) begin
      if (i_frame_start) begin
        o_busy <= 1'b1;
        o_mode <= i_mode;
      end
    end else if (o_frame_done) begin
      o_busy <= 1'b0;
    end
  end

  // sample and result counters, cleared on start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_cnt  <= '0;
      out_cnt <= '0;
    end else if (!o_busy && i_frame_start) begin
      in_cnt  <= '0;
      out_cnt <= '0;
    end else begin
      if (accept) begin
        in_cnt <= in_cnt + 1'b1;
      end
      if (o_busy && i_y_valid) begin
        out_cnt <= out_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // sample stage
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_x_valid <= 1'b0;
    end else begin
      o_x_valid <= accept;
    end
  end

  // payload, follows the input every cycle
  always_ff @(posedge clk) begin
    o_x <= i_x;
  end

  // never more samples than positions in a frame
  assert property (@(posedge clk) disable iff (!rst_n) in_cnt <= CNT_W'(FRAME_LEN));

  // last result can't leave before every sample went in
  assert property (@(posedge clk) disable iff (!rst_n)
    o_frame_done |-> o_busy && (in_cnt == CNT_W'(FRAME_LEN)));

endmodule

//--- hw/chirp_proc_top.sv
`timescale 1ns/1ps

module chirp_proc_top #(
  parameter int FRAME_LEN = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // weight load, ignored while busy
  input  logic                     i_w_we,
  input  logic [((FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1)-1:0] i_w_addr,
  input  chirp_types_pkg::sample_u i_w_data,
  // frame control
  input  logic                     i_frame_start,
  input  chirp_cfg_pkg::mode_e     i_mode,
  // sample stream
  input  logic                     i_valid,
  input  chirp_types_pkg::sample_u i_x,
  // results
  output logic                     o_valid,
  output chirp_types_pkg::sample_u o_y,
  // status
  output logic                     o_busy,
  output logic                     o_frame_done
);

  // one weight slot per sample position
  localparam int ADDR_W = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;

  logic [ADDR_W-1:0]        raddr;
  chirp_types_pkg::sample_u w_rdata;
  chirp_cfg_pkg::mode_e     mode_q;
  chirp_types_pkg::sample_u x_d;
  logic                     x_d_valid;

  // sequencing, mode latch and addressing
  chirp_frame_ctrl #(.FRAME_LEN(FRAME_LEN), .ADDR_W(ADDR_W)) u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_frame_start (i_frame_start),
    .i_mode        (i_mode),
    .i_valid       (i_valid),
    .i_x           (i_x),
    .i_y_valid     (o_valid),
    .o_raddr       (raddr),
    .o_mode        (mode_q),
    .o_x           (x_d),
    .o_x_valid     (x_d_valid),
    .o_busy        (o_busy),
    .o_frame_done  (o_frame_done)
  );

  // weights, write locked out during a frame
  chirp_weight_ram #(.ADDR_W(ADDR_W)) u_wram (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_we    (i_w_we && !o_busy),
    .i_waddr (i_w_addr),
    .i_wdata (i_w_data),
    .i_raddr (raddr),
    .o_rdata (w_rdata)
  );

  // sample times weight
  chirp_weight_mult u_wmult (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_mode  (mode_q),
    .i_x     (x_d),
    .i_w     (w_rdata),
    .i_valid (x_d_valid),
    .o_y     (o_y),
    .o_valid (o_valid)
  );

endmodule

//--- tb/chirp_proc_tb.sv
`timescale 1ns/1ps

module chirp_proc_tb;

  localparam int FRAME_LEN     = 8;
  localparam int ADDR_W        = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;
  localparam int NROWS         = 6;
  localparam int CLK_PERIOD_NS = 40;
  localparam int RST_CYCLES    = 3;
  // per-row budget plus reset and a little slack
  localparam int WATCHDOG_NS   =
    (NROWS * (FRAME_LEN + 20) + RST_CYCLES + 2) * CLK_PERIOD_NS;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     i_w_we;
  logic [ADDR_W-1:0]        i_w_addr;
  chirp_types_pkg::sample_u i_w_data;
  logic                     i_frame_start;
  chirp_cfg_pkg::mode_e     i_mode;
  logic                     i_valid;
  chirp_types_pkg::sample_u i_x;
  logic                     o_valid;
  chirp_types_pkg::sample_u o_y;
  logic                     o_busy;
  logic                     o_frame_done;

  // stimulus table, one frame per row
  chirp_cfg_pkg::mode_e     tbl_mode [NROWS];
  chirp_types_pkg::sample_u tbl_x    [NROWS][FRAME_LEN];
  chirp_types_pkg::sample_u tbl_w    [NROWS][FRAME_LEN];
  bit                       tbl_gap  [NROWS];

  // corner lane values for the hand rows
  chirp_types_pkg::lane_t corner [8] = '{16'sh8000, 16'sh7fff, 16'shffff, 16'sh0001,
                                         16'sh0000, 16'sh8001, 16'sh0100, 16'shff7f};

  // collected results and their cycles
  chirp_types_pkg::sample_u got_y [$];
  int                       got_cyc [$];
  int                       done_cnt;
  int                       done_cyc;
  logic                     done_busy;
  logic                     busy_now;

  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;

  chirp_proc_top #(.FRAME_LEN(FRAME_LEN)) chirp_proc_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_w_we        (i_w_we),
    .i_w_addr      (i_w_addr),
    .i_w_data      (i_w_data),
    .i_frame_start (i_frame_start),
    .i_mode        (i_mode),
    .i_valid       (i_valid),
    .i_x           (i_x),
    .o_valid       (o_valid),
    .o_y           (o_y),
    .o_busy        (o_busy),
    .o_frame_done  (o_frame_done)
  );

  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  // rising edges seen so far
  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////
  // reference model
  ////////////////////

  // sign of the full product, then its low 15 bits
  function automatic chirp_types_pkg::lane_t pack_lane(input longint v);
    chirp_types_pkg::lane_t r;
    r[15]   = (v < 0);
    r[14:0] = v[14:0];
    return r;
  endfunction

  function automatic chirp_types_pkg::sample_u expected_word(
    input chirp_cfg_pkg::mode_e mode,
    input chirp_types_pkg::sample_u x,
    input chirp_types_pkg::sample_u w
  );
    chirp_types_pkg::sample_u y;
    longint a, b, c, d;
    if (mode == chirp_cfg_pkg::MODE_REAL) begin
      a = x.dual.lo;
      b = x.dual.hi;
      c = w.dual.lo;
      d = w.dual.hi;
      y.dual.lo = pack_lane(a * c);
      y.dual.hi = pack_lane(b * d);
    end else begin
      // (a + jb)(c + jd)
      a = x.cplx.re;
      b = x.cplx.imag;
      c = w.cplx.re;
      d = w.cplx.imag;
      y.cplx.re   = pack_lane(a * c - b * d);
      y.cplx.imag = pack_lane(a * d + b * c);
    end
    return y;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] t;
    t = s;
    t = t ^ (t << 13);
    t = t ^ (t >> 17);
    t = t ^ (t << 5);
    return t;
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic check_word(input chirp_types_pkg::sample_u got,
                            input chirp_types_pkg::sample_u exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input integer got, input integer exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // wait a falling edge, record what the DUT shows there
  task automatic next_cycle();
    @(negedge clk);
    if (o_valid === 1'b1) begin
      got_y.push_back(o_y);
      got_cyc.push_back(cyc);
    end
    if (o_frame_done === 1'b1) begin
      done_cnt++;
      done_cyc  = cyc;
      done_busy = o_busy;
    end
    busy_now = o_busy;
  endtask

  task automatic fill_table();
    logic [31:0] rng;
    rng = 32'd78;
    for (int r = 0; r < NROWS; r++) begin
      tbl_mode[r] = (r % 2) ? chirp_cfg_pkg::MODE_REAL : chirp_cfg_pkg::MODE_COMPLEX;
      tbl_gap[r]  = (r == 1) || (r == 2) || (r == 5);
    end
    // rows 0 and 1 from corner values, rest random
    for (int k = 0; k < FRAME_LEN; k++) begin
      tbl_x[0][k] = {corner[k % 8], corner[(7 - k) % 8]};
      tbl_w[0][k] = {corner[(k + 3) % 8], corner[(k + 5) % 8]};
      tbl_x[1][k] = {corner[(k + 1) % 8], corner[k % 8]};
      tbl_w[1][k] = {corner[(k + 6) % 8], corner[(k + 2) % 8]};
    end
    // most negative times most negative
    tbl_x[0][0] = 32'h8000_8000;
    tbl_w[0][0] = 32'h8000_8000;
    tbl_x[1][FRAME_LEN-1] = 32'h8000_8000;
    tbl_w[1][FRAME_LEN-1] = 32'h8000_8000;
    for (int r = 2; r < NROWS; r++) begin
      for (int k = 0; k < FRAME_LEN; k++) begin
        rng = xorshift32(rng);
        tbl_x[r][k] = rng;
        rng = xorshift32(rng);
        tbl_w[r][k] = rng;
      end
    end
  endtask

  ////////////////////
  // one frame per row
  ////////////////////

  task automatic run_row(input int r);
    int first_err;
    int lat;
    int waited;
    int in_cyc [FRAME_LEN];
    chirp_types_pkg::sample_u exp_y;
    chirp_cfg_pkg::mode_e other;
    first_err = errors;
    lat   = (tbl_mode[r] == chirp_cfg_pkg::MODE_REAL) ? 4 : 7;
    other = (tbl_mode[r] == chirp_cfg_pkg::MODE_REAL) ? chirp_cfg_pkg::MODE_COMPLEX
                                                      : chirp_cfg_pkg::MODE_REAL;
    got_y.delete();
    got_cyc.delete();
    done_cnt = 0;
    done_cyc = -1;
    // weight load while idle, junk samples alongside must be dropped
    for (int k = 0; k < FRAME_LEN; k++) begin
      next_cycle();
      i_w_we        = 1'b1;
      i_w_addr      = ADDR_W'(k);
      i_w_data      = tbl_w[r][k];
      i_valid       = 1'b1;
      i_x           = ~tbl_x[r][k];
      i_mode        = tbl_mode[r];
      i_frame_start = (k == FRAME_LEN - 1);
    end
    // stream, with flipped mode, stray start and blocked weight writes
    for (int k = 0; k < FRAME_LEN; k++) begin
      next_cycle();
      if (k == 0) begin
        check_count(busy_now, 1, $sformatf("row %0d busy after start", r));
      end
      i_frame_start = (k == 4);
      i_mode        = other;
      i_w_we        = 1'b1;
      i_w_addr      = ADDR_W'(k);
      i_w_data      = ~tbl_w[r][k];
      i_valid       = 1'b1;
      i_x           = tbl_x[r][k];
      in_cyc[k]     = cyc;
      if (tbl_gap[r] && (k == 2 || k == 5)) begin
        next_cycle();
        i_valid = 1'b0;
        i_x     = '0;
      end
    end
    // one sample past the frame end
    next_cycle();
    i_frame_start = 1'b0;
    i_w_we        = 1'b0;
    i_valid       = 1'b1;
    i_x           = tbl_x[r][0];
    next_cycle();
    i_valid = 1'b0;
    i_mode  = tbl_mode[r];
    waited  = 0;
    while (done_cnt == 0 && waited < 20) begin
      next_cycle();
      waited++;
    end
    if (done_cnt == 0) begin
      errors++;
      $display("frame done never arrived in row %0d", r);
    end else begin
      // busy drops right after done; late outputs would land here too
      next_cycle();
      check_count(busy_now, 0, $sformatf("row %0d busy after frame done", r));
      check_count(done_busy, 1, $sformatf("row %0d busy with frame done", r));
    end
    check_count(got_y.size(), FRAME_LEN, $sformatf("row %0d results", r));
    check_count(done_cnt, 1, $sformatf("row %0d frame done pulses", r));
    if (got_y.size() >= FRAME_LEN) begin
      check_count(done_cyc, got_cyc[FRAME_LEN-1], $sformatf("row %0d done cycle", r));
    end
    for (int k = 0; k < FRAME_LEN && k < got_y.size(); k++) begin
      exp_y = expected_word(tbl_mode[r], tbl_x[r][k], tbl_w[r][k]);
      check_word(got_y[k], exp_y, $sformatf("row %0d result %0d", r, k));
      check_count(got_cyc[k] - in_cyc[k], lat, $sformatf("row %0d latency %0d", r, k));
    end
    tests_run++;
    if (errors != first_err) begin
      tests_failed++;
    end
    $display("test row %0d %s gap=%0d: %s", r, tbl_mode[r].name(), tbl_gap[r],
             (errors == first_err) ? "ok" : "FAILED");
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int first_err;
    rst_n         = 1'b0;
    i_w_we        = 1'b0;
    i_w_addr      = '0;
    i_w_data      = '0;
    i_frame_start = 1'b0;
    i_mode        = chirp_cfg_pkg::MODE_COMPLEX;
    i_valid       = 1'b0;
    i_x           = '0;
    fill_table();
    // outputs quiet in and right after reset
    first_err = errors;
    for (int i = 0; i <= RST_CYCLES; i++) begin
      next_cycle();
      if (i == RST_CYCLES - 1) begin
        rst_n = 1'b1;
      end
      check_count(o_valid, 0, "o_valid in reset");
      check_count(o_busy, 0, "o_busy in reset");
      check_count(o_frame_done, 0, "o_frame_done in reset");
      check_word(o_y, '0, "o_y in reset");
    end
    tests_run++;
    if (errors != first_err) begin
      tests_failed++;
    end
    $display("test reset: %s", (errors == first_err) ? "ok" : "FAILED");
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- src.f
hw/chirp_types_pkg.sv
hw/chirp_cfg_pkg.sv
hw/chirp_pipe_mult.sv
hw/chirp_weight_ram.sv
hw/chirp_weight_mult.sv
hw/chirp_frame_ctrl.sv
hw/chirp_proc_top.sv
tb/chirp_proc_tb.sv
